/* common/emesh_params.svh */
`ifndef EMESH_PARAMS_SVH
`define EMESH_PARAMS_SVH

//####################
// Packet geometry
//####################
`define EMESH_PW            104      // Full eMesh packet
`define EMESH_AW            32       // Address field
`define EMESH_DW            32       // Data field

//####################
// Memory organisation
//####################
`define EMESH_NUM_BANKS     4        // Banks selected by dst_addr[3:2]
`define EMESH_BANK_DEPTH    64       // Words per bank, dst_addr[9:4]

//####################
// Credit budgets
//####################
`define EMESH_IN_CREDITS    4        // Dispatcher input FIFO depth
`define EMESH_BANK_CREDITS  2        // Bank request queue depth
`define EMESH_MERGE_CREDITS 2        // Merger slot depth per bank
`define EMESH_OUT_CREDITS   4        // Initial credit toward sink

`define EMESH_CHIP_ID       12'h808  // Own chip ID in dst_addr[31:20]

`endif

/* common/emesh_pkg.sv */
`include "emesh_params.svh"

package emesh_pkg;

   // Layout {src_addr, data, dst_addr, ctrlmode, datamode, write}
   typedef logic [`EMESH_PW-1:0] emesh_packet_t;

   typedef enum logic {
      CMD_READ  = 1'b0,                                  // Write bit clear
      CMD_WRITE = 1'b1
   } emesh_cmd_e;

   typedef enum logic {
      MERGE_IDLE = 1'b0,                                 // Nothing in output register
      MERGE_SEND = 1'b1                                  // Output register holds a response
   } merge_state_e;

   localparam int BANK_W = $clog2(`EMESH_NUM_BANKS);    // Bank select bits
   localparam int WORD_W = $clog2(`EMESH_BANK_DEPTH);   // Word index bits

   function automatic emesh_cmd_e pkt_cmd(emesh_packet_t pkt);
      return emesh_cmd_e'(pkt[0]);
   endfunction

   function automatic logic [`EMESH_AW-1:0] pkt_dst_addr(emesh_packet_t pkt);
      return pkt[8 +: `EMESH_AW];
   endfunction

   function automatic logic [`EMESH_DW-1:0] pkt_data(emesh_packet_t pkt);
      return pkt[8+`EMESH_AW +: `EMESH_DW];
   endfunction

   function automatic logic [`EMESH_AW-1:0] pkt_src_addr(emesh_packet_t pkt);
      return pkt[8+`EMESH_AW+`EMESH_DW +: `EMESH_AW];
   endfunction

   function automatic logic [11:0] pkt_chip_id(emesh_packet_t pkt);
      return pkt[8+`EMESH_AW-1 -: 12];                   // Top 12 address bits
   endfunction

   function automatic logic [BANK_W-1:0] pkt_bank(emesh_packet_t pkt);
      return pkt[8+2 +: BANK_W];                         // Word-interleaved banks
   endfunction

   function automatic logic [WORD_W-1:0] pkt_word(emesh_packet_t pkt);
      return pkt[8+2+BANK_W +: WORD_W];
   endfunction

   // Read response goes back to the requester as a write
   function automatic emesh_packet_t build_response(emesh_packet_t req,
                                                    logic [`EMESH_DW-1:0] rdata);
      emesh_packet_t rsp;
      rsp = '0;
      rsp[0]                               = 1'b1;               // Write
      rsp[7:1]                             = req[7:1];           // Datamode, ctrlmode
      rsp[8 +: `EMESH_AW]                  = pkt_src_addr(req);  // Return address
      rsp[8+`EMESH_AW +: `EMESH_DW]        = rdata;
      rsp[8+`EMESH_AW+`EMESH_DW +: `EMESH_AW] = pkt_dst_addr(req);
      return rsp;
   endfunction

endpackage

/* hw/emesh_dispatch.sv */
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_dispatch (
   input  logic                          sys_clk,
   input  logic                          reset,
   input  logic                          in_access,
   input  emesh_pkg::emesh_packet_t      in_packet,
   input  logic [`EMESH_NUM_BANKS-1:0]   req_credit,
   output logic                          in_credit,
   output logic                          dropped,
   output logic [`EMESH_NUM_BANKS-1:0]   req_access,
   output emesh_pkg::emesh_packet_t      req_packet [`EMESH_NUM_BANKS]
);

   import emesh_pkg::*;

   localparam int DEPTH  = `EMESH_IN_CREDITS;
   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W  = $clog2(DEPTH + 1);
   localparam int BCNT_W = $clog2(`EMESH_BANK_CREDITS + 1);

   emesh_packet_t     fifo_mem [DEPTH];                  // Input buffer storage
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  fifo_cnt;                          // Occupied entries
   logic [BCNT_W-1:0] bank_cnt [`EMESH_NUM_BANKS];      // Credits held per bank

   emesh_packet_t     head;
   logic              head_valid;
   logic              head_foreign;                      // Chip ID mismatch
   logic [BANK_W-1:0] head_bank;
   logic              fwd_ok;                            // Head may leave toward a bank
   logic              pop;

   //####################
   // Head decode
   //####################
   always_comb begin
      head         = fifo_mem[rd_ptr];
      head_valid   = (fifo_cnt != '0);
      head_foreign = (pkt_chip_id(head) != `EMESH_CHIP_ID);
      head_bank    = pkt_bank(head);
      fwd_ok       = head_valid && !head_foreign && (bank_cnt[head_bank] != '0);
      pop          = fwd_ok || (head_valid && head_foreign);  // Drops never wait
      in_credit    = pop;                                     // Entry freed
      dropped      = pop && head_foreign;
      for (int k = 0; k < `EMESH_NUM_BANKS; k++) begin
         req_access[k] = fwd_ok && (head_bank == BANK_W'(k));
         req_packet[k] = head;                                // Shared payload bus
      end
   end

   //####################
   // Input FIFO
   //####################
   always_ff @(posedge sys_clk) begin
      if (in_access)
         fifo_mem[wr_ptr] <= in_packet;                       // Source never overruns
   end

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fifo_cnt <= '0;
      end else begin
         if (in_access)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({in_access, pop})
            2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
            2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
            default: fifo_cnt <= fifo_cnt;              // Idle or push with pop
         endcase
      end
   end

   //####################
   // Bank credits
   //####################
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         for (int k = 0; k < `EMESH_NUM_BANKS; k++)
            bank_cnt[k] <= BCNT_W'(`EMESH_BANK_CREDITS);  // Full bank queue
      end else begin
         for (int k = 0; k < `EMESH_NUM_BANKS; k++) begin
            case ({req_access[k], req_credit[k]})
               2'b10:   bank_cnt[k] <= bank_cnt[k] - 1'b1;  // Sent
               2'b01:   bank_cnt[k] <= bank_cnt[k] + 1'b1;  // Returned
               default: bank_cnt[k] <= bank_cnt[k];
            endcase
         end
      end
   end

endmodule

/* ememory/emesh_memory_bank.sv */
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_memory_bank (
   input  logic                      sys_clk,
   input  logic                      reset,
   input  logic                      req_access,
   input  emesh_pkg::emesh_packet_t  req_packet,
   input  logic                      rsp_credit,
   output logic                      req_credit,
   output logic                      rsp_access,
   output emesh_pkg::emesh_packet_t  rsp_packet
);

   import emesh_pkg::*;

   localparam int DEPTH  = `EMESH_BANK_CREDITS;
   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W  = $clog2(DEPTH + 1);
   localparam int RCNT_W = $clog2(`EMESH_MERGE_CREDITS + 1);

   emesh_packet_t        q_mem [DEPTH];                  // Request queue
   logic [PTR_W-1:0]     q_wr;
   logic [PTR_W-1:0]     q_rd;
   logic [CNT_W-1:0]     q_cnt;
   logic [`EMESH_DW-1:0] storage [`EMESH_BANK_DEPTH];   // Word array

   emesh_packet_t        head;
   emesh_cmd_e           head_cmd;
   logic [WORD_W-1:0]    head_word;
   logic                 head_valid;
   logic                 do_write;
   logic                 do_read;
   logic                 pop;
   logic [RCNT_W-1:0]    rsp_cnt;                        // Free merger slot entries

   //####################
   // Request decode
   //####################
   always_comb begin
      head       = q_mem[q_rd];
      head_cmd   = pkt_cmd(head);
      head_word  = pkt_word(head);
      head_valid = (q_cnt != '0);
      do_write   = head_valid && (head_cmd == CMD_WRITE);  // Writes always drain
      do_read    = head_valid && (head_cmd == CMD_READ) && (rsp_cnt != '0);
      pop        = do_write || do_read;
      req_credit = pop;                                    // Queue entry freed
   end

   // Head-of-line order in the request queue keeps responses in sequence
   always_ff @(posedge sys_clk) begin
      if (req_access)
         q_mem[q_wr] <= req_packet;
   end

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         q_wr  <= '0;
         q_rd  <= '0;
         q_cnt <= '0;
      end else begin
         if (req_access)
            q_wr <= (q_wr == PTR_W'(DEPTH - 1)) ? '0 : q_wr + 1'b1;
         if (pop)
            q_rd <= (q_rd == PTR_W'(DEPTH - 1)) ? '0 : q_rd + 1'b1;
         case ({req_access, pop})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: q_cnt <= q_cnt;
         endcase
      end
   end

   //####################
   // Storage and response
   //####################
   always_ff @(posedge sys_clk) begin
      if (do_write)
         storage[head_word] <= pkt_data(head);             // Commit on pop
      if (do_read)
         rsp_packet <= build_response(head, storage[head_word]);
   end

   always_ff @(posedge sys_clk) begin
      if (reset)
         rsp_access <= 1'b0;
      else
         rsp_access <= do_read;                            // One cycle after pop
   end

   // Credit toward the merger slot
   always_ff @(posedge sys_clk) begin
      if (reset) begin
         rsp_cnt <= RCNT_W'(`EMESH_MERGE_CREDITS);
      end else begin
         case ({do_read, rsp_credit})
            2'b10:   rsp_cnt <= rsp_cnt - 1'b1;            // Response reserved
            2'b01:   rsp_cnt <= rsp_cnt + 1'b1;            // Slot entry left
            default: rsp_cnt <= rsp_cnt;
         endcase
      end
   end

endmodule

/* hw/emesh_response_merge.sv */
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_response_merge (
   input  logic                          sys_clk,
   input  logic                          reset,
   input  logic [`EMESH_NUM_BANKS-1:0]   rsp_access,
   input  emesh_pkg::emesh_packet_t      rsp_packet [`EMESH_NUM_BANKS],
   input  logic                          out_credit,
   output logic [`EMESH_NUM_BANKS-1:0]   rsp_credit,
   output logic                          out_access,
   output emesh_pkg::emesh_packet_t      out_packet
);

   import emesh_pkg::*;

   localparam int NB     = `EMESH_NUM_BANKS;
   localparam int DEPTH  = `EMESH_MERGE_CREDITS;
   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W  = $clog2(DEPTH + 1);
   localparam int OCNT_W = $clog2(`EMESH_OUT_CREDITS + 1);

   emesh_packet_t     slot_mem [NB][DEPTH];              // One small FIFO per bank
   logic [PTR_W-1:0]  slot_wr [NB];
   logic [PTR_W-1:0]  slot_rd [NB];
   logic [CNT_W-1:0]  slot_cnt [NB];
   logic [NB-1:0]     slot_busy;

   merge_state_e      state;
   logic [BANK_W-1:0] rr_ptr;                            // Next bank to look at first
   logic [BANK_W-1:0] pick;
   logic              pick_ok;
   logic              send;
   logic [OCNT_W-1:0] out_cnt;                           // Credits left at the sink

   //####################
   // Round-robin pick
   //####################
   always_comb begin
      int idx;
      pick    = rr_ptr;
      pick_ok = 1'b0;
      for (int k = 0; k < NB; k++)
         slot_busy[k] = (slot_cnt[k] != '0);
      for (int i = 0; i < NB; i++) begin
         idx = (int'(rr_ptr) + i) % NB;                  // Wrap around the banks
         if (!pick_ok && slot_busy[idx]) begin
            pick    = BANK_W'(idx);
            pick_ok = 1'b1;
         end
      end
      send = pick_ok && (out_cnt != '0);
      for (int k = 0; k < NB; k++)
         rsp_credit[k] = send && (pick == BANK_W'(k)); // Slot entry leaves
   end

   //####################
   // Per-bank slots
   //####################
   always_ff @(posedge sys_clk) begin
      for (int k = 0; k < NB; k++)
         if (rsp_access[k])
            slot_mem[k][slot_wr[k]] <= rsp_packet[k];
   end

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         for (int k = 0; k < NB; k++) begin
            slot_wr[k]  <= '0;
            slot_rd[k]  <= '0;
            slot_cnt[k] <= '0;
         end
      end else begin
         for (int k = 0; k < NB; k++) begin
            if (rsp_access[k])
               slot_wr[k] <= (slot_wr[k] == PTR_W'(DEPTH - 1)) ? '0 : slot_wr[k] + 1'b1;
            if (rsp_credit[k])
               slot_rd[k] <= (slot_rd[k] == PTR_W'(DEPTH - 1)) ? '0 : slot_rd[k] + 1'b1;
            case ({rsp_access[k], rsp_credit[k]})
               2'b10:   slot_cnt[k] <= slot_cnt[k] + 1'b1;
               2'b01:   slot_cnt[k] <= slot_cnt[k] - 1'b1;
               default: slot_cnt[k] <= slot_cnt[k];
            endcase
         end
      end
   end

   //####################
   // Output stage
   //####################
   always_ff @(posedge sys_clk) begin
      if (send)
         out_packet <= slot_mem[pick][slot_rd[pick]];
   end

   always_ff @(posedge sys_clk) begin
      if (reset) begin
         state   <= MERGE_IDLE;
         rr_ptr  <= '0;
         out_cnt <= OCNT_W'(`EMESH_OUT_CREDITS);
      end else begin
         state <= send ? MERGE_SEND : MERGE_IDLE;        // Back-to-back sends allowed
         if (send)
            rr_ptr <= (pick == BANK_W'(NB - 1)) ? '0 : pick + 1'b1;  // Past the winner
         case ({send, out_credit})
            2'b10:   out_cnt <= out_cnt - 1'b1;
            2'b01:   out_cnt <= out_cnt + 1'b1;          // Sink freed an entry
            default: out_cnt <= out_cnt;
         endcase
      end
   end

   assign out_access = (state == MERGE_SEND);

endmodule

/* hw/emesh_example.sv */
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_example (
   input  logic                      sys_clk,
   input  logic                      reset,
   input  logic                      in_access,
   input  emesh_pkg::emesh_packet_t  in_packet,
   input  logic                      out_credit,
   output logic                      in_credit,
   output logic                      dropped,
   output logic                      out_access,
   output emesh_pkg::emesh_packet_t  out_packet
);

   import emesh_pkg::*;

   // Dispatcher to banks
   logic [`EMESH_NUM_BANKS-1:0] req_access;
   emesh_packet_t               req_packet [`EMESH_NUM_BANKS];
   logic [`EMESH_NUM_BANKS-1:0] req_credit;

   // Banks to merger
   logic [`EMESH_NUM_BANKS-1:0] rsp_access;
   emesh_packet_t               rsp_packet [`EMESH_NUM_BANKS];
   logic [`EMESH_NUM_BANKS-1:0] rsp_credit;

   //####################
   // Dispatcher
   //####################
   emesh_dispatch u_dispatch (
      .sys_clk    (sys_clk),
      .reset      (reset),
      .in_access  (in_access),
      .in_packet  (in_packet),
      .req_credit (req_credit),
      .in_credit  (in_credit),
      .dropped    (dropped),          // Foreign chip ID
      .req_access (req_access),
      .req_packet (req_packet)
   );

   //####################
   // Memory banks
   //####################
   for (genvar k = 0; k < `EMESH_NUM_BANKS; k++) begin : g_bank
      emesh_memory_bank u_bank (
         .sys_clk    (sys_clk),
         .reset      (reset),
         .req_access (req_access[k]),
         .req_packet (req_packet[k]),
         .rsp_credit (rsp_credit[k]),
         .req_credit (req_credit[k]),
         .rsp_access (rsp_access[k]),
         .rsp_packet (rsp_packet[k])
      );
   end

   //####################
   // Response merger
   //####################
   emesh_response_merge u_merge (
      .sys_clk    (sys_clk),
      .reset      (reset),
      .rsp_access (rsp_access),
      .rsp_packet (rsp_packet),
      .out_credit (out_credit),
      .rsp_credit (rsp_credit),
      .out_access (out_access),       // Read responses only
      .out_packet (out_packet)
   );

endmodule

/* bench/emesh_example_tb.sv */
`timescale 1ns/1ps
`include "emesh_params.svh"

module emesh_example_tb;

   import emesh_pkg::*;

   localparam int CLK_PERIOD      = 100;
   localparam int NUM_PACKETS     = 236;                 // 8 + 12 + 4 + 12 + 200
   localparam int WATCHDOG_CYCLES = NUM_PACKETS * 20 + 2000;
   localparam int SETTLE_CYCLES   = 20;                  // Quiet time before comparing
   localparam int MEM_WORDS       = `EMESH_NUM_BANKS * `EMESH_BANK_DEPTH;

   logic                 sys_clk;
   logic                 reset;
   logic                 in_access;
   emesh_packet_t        in_packet;
   logic                 out_credit;
   logic                 in_credit;
   logic                 dropped;
   logic                 out_access;
   emesh_packet_t        out_packet;

   int                   error_count;
   int                   src_credits;                    // Source side credit counter
   int                   owed_credits;                   // Sink credits not yet returned
   int                   drop_count;
   int                   in_credit_count;
   int                   rsp_total;
   logic                 sink_open;
   logic                 gate_random;                    // Random sink gating enable
   logic [31:0]          rng_state;
   logic [31:0]          gate_state;
   logic [31:0]          next_tag;                       // Unique return addresses
   logic [`EMESH_DW-1:0] ref_mem [MEM_WORDS];            // Indexed by dst_addr[9:2]
   logic                 written [MEM_WORDS];
   logic [31:0]          bank_addr [`EMESH_NUM_BANKS];   // One known word per bank
   emesh_packet_t        exp_q [$];
   emesh_packet_t        rx_q [$];

   emesh_example u_emesh_example (
      .sys_clk    (sys_clk),
      .reset      (reset),
      .in_access  (in_access),
      .in_packet  (in_packet),
      .out_credit (out_credit),
      .in_credit  (in_credit),
      .dropped    (dropped),
      .out_access (out_access),
      .out_packet (out_packet)
   );

   initial sys_clk = 1'b0;
   always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

   //####################
   // Source and sink models
   //####################
   always @(posedge sys_clk) begin
      if (reset) begin
         src_credits = `EMESH_IN_CREDITS;                // Matches input FIFO depth
      end else begin
         if (in_credit) begin
            src_credits++;
            in_credit_count++;
         end
         if (dropped)
            drop_count++;
      end
   end

   always @(posedge sys_clk) begin
      logic open_now;
      open_now = sink_open;
      if (!reset && out_access) begin
         rx_q.push_back(out_packet);                     // Registered output is stable here
         rsp_total++;
         owed_credits++;
      end
      #5;
      if (open_now && owed_credits > 0) begin
         out_credit = 1'b1;                              // One credit per cycle
         owed_credits--;
      end else begin
         out_credit = 1'b0;
      end
   end

   // Gate flips away from both edge-side processes
   always @(negedge sys_clk) begin
      if (gate_random) begin
         gate_state = xorshift32(gate_state);
         sink_open  = (gate_state[1:0] != 2'b00);        // Open about 3 of 4 cycles
      end
   end

   //####################
   // Helpers
   //####################
   function automatic logic [31:0] xorshift32(logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Chip ID on top, bank in bits 3:2, word in bits 9:4
   function automatic logic [31:0] word_address(logic [11:0] chip, logic [1:0] bank,
                                                logic [5:0] word);
      return {chip, 10'h000, word, bank, 2'b00};
   endfunction

   function automatic emesh_packet_t make_request(logic wr, logic [31:0] dst,
                                                  logic [31:0] data, logic [31:0] src,
                                                  logic [4:0] ctrl);
      return {src, data, dst, ctrl, 2'b10, wr};          // Word datamode
   endfunction

   // Addresses swap, modes copied, write bit set
   function automatic emesh_packet_t make_read_response(emesh_packet_t req,
                                                        logic [31:0] data);
      return {req[39:8], data, req[103:72], req[7:1], 1'b1};
   endfunction

   task automatic check_packet(emesh_packet_t got, emesh_packet_t exp, string what);
      if (got !== exp) begin
         error_count++;
         $display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(int got, int exp, string what);
      if (got != exp) begin
         error_count++;
         $display("Fail at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic idle_cycles(int n);
      repeat (n) @(posedge sys_clk);
      #5;                                                // Back to the drive point
   endtask

   task automatic send_packet(emesh_packet_t pkt);
      while (src_credits == 0)
         idle_cycles(1);
      in_access = 1'b1;
      in_packet = pkt;
      src_credits--;
      idle_cycles(1);
      in_access = 1'b0;
   endtask

   task automatic send_write(logic [31:0] dst, logic [31:0] data);
      logic [31:0] r;
      r = next_random();
      ref_mem[dst[9:2]] = data;
      written[dst[9:2]] = 1'b1;
      send_packet(make_request(1'b1, dst, data, 32'h0, r[4:0]));
   endtask

   task automatic send_read(logic [31:0] dst);
      emesh_packet_t req;
      logic [31:0]   r;
      r = next_random();
      req = make_request(1'b0, dst, r, 32'h0a00_0000 + next_tag, r[4:0]);
      next_tag++;
      exp_q.push_back(make_read_response(req, ref_mem[dst[9:2]]));
      send_packet(req);
   endtask

   task automatic wait_responses(int n);
      while (rx_q.size() < n)
         idle_cycles(1);
      idle_cycles(SETTLE_CYCLES);                        // Catch any extra response
   endtask

   task automatic compare_in_order();
      check_count(rx_q.size(), exp_q.size(), "response count");
      for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++)
         check_packet(rx_q[i], exp_q[i], "response in bank order");
      rx_q.delete();
      exp_q.delete();
   endtask

   // Order across banks is free, so pair by return address
   task automatic match_by_address();
      int found;
      for (int i = 0; i < rx_q.size(); i++) begin
         found = -1;
         for (int j = 0; j < exp_q.size(); j++)
            if (found < 0 && exp_q[j][39:8] == rx_q[i][39:8])
               found = j;
         if (found < 0) begin
            error_count++;
            $display("Unexpected response with return address %h", rx_q[i][39:8]);
         end else begin
            check_packet(rx_q[i], exp_q[found], "matched response");
            exp_q.delete(found);
         end
      end
      check_count(exp_q.size(), 0, "responses still missing");
      rx_q.delete();
      exp_q.delete();
   endtask

   //####################
   // Directed tests
   //####################
   task automatic write_then_read();
      logic [31:0] r;
      for (int k = 0; k < `EMESH_NUM_BANKS; k++) begin
         r = next_random();
         bank_addr[k] = word_address(`EMESH_CHIP_ID, k[1:0], r[5:0]);
         send_write(bank_addr[k], next_random());
      end
      for (int k = 0; k < `EMESH_NUM_BANKS; k++)
         send_read(bank_addr[k]);
      wait_responses(`EMESH_NUM_BANKS);
      match_by_address();
   endtask

   task automatic read_order_in_bank();
      int w;
      for (int i = 0; i < 6; i++)
         send_write(word_address(`EMESH_CHIP_ID, 2'd1, i[5:0]), next_random());
      for (int i = 0; i < 6; i++) begin
         w = 5 - i;                                      // Reverse word order
         send_read(word_address(`EMESH_CHIP_ID, 2'd1, w[5:0]));
      end
      wait_responses(6);
      compare_in_order();
   endtask

   task automatic filter_foreign_chip();
      int base;
      base = drop_count;
      send_packet(make_request(1'b0, word_address(12'h123, 2'd0, 6'd0), 32'h0,
                               32'h0b00_0000, 5'h00));
      send_packet(make_request(1'b1, word_address(12'h809, 2'd1, 6'd3), 32'hdead_beef,
                               32'h0b00_0001, 5'h00));  // Would corrupt bank 1 word 3
      send_packet(make_request(1'b0, word_address(12'h000, 2'd2, 6'd1), 32'h0,
                               32'h0b00_0002, 5'h00));
      while (drop_count - base < 3)
         idle_cycles(1);
      idle_cycles(SETTLE_CYCLES);
      check_count(drop_count - base, 3, "dropped pulses");
      check_count(rx_q.size(), 0, "responses to foreign packets");
      send_read(word_address(`EMESH_CHIP_ID, 2'd1, 6'd3));
      wait_responses(1);
      match_by_address();
   endtask

   task automatic stall_sink();
      int base;
      sink_open = 1'b0;
      for (int i = 0; i < 12; i++)                       // Exactly fills the bank 0 path
         send_read(bank_addr[0]);
      while (rx_q.size() < `EMESH_OUT_CREDITS)
         idle_cycles(1);
      idle_cycles(SETTLE_CYCLES);                        // Stall spreads back to the source
      base = in_credit_count;
      idle_cycles(SETTLE_CYCLES);
      check_count(in_credit_count - base, 0, "in_credit pulses while stalled");
      check_count(rx_q.size(), `EMESH_OUT_CREDITS, "responses while sink withholds credit");
      sink_open = 1'b1;
      wait_responses(12);
      compare_in_order();
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      logic [31:0] addr;
      int          reads;
      int          base_total;
      reads       = 0;
      base_total  = rsp_total;
      gate_random = 1'b1;
      for (int n = 0; n < 200; n++) begin
         r    = next_random();
         addr = word_address(`EMESH_CHIP_ID, r[1:0], {3'b000, r[4:2]});  // 32 hot words
         if (r[8] && written[addr[9:2]]) begin
            send_read(addr);
            reads++;
         end else begin
            send_write(addr, next_random());
         end
      end
      gate_random = 1'b0;
      sink_open   = 1'b1;
      wait_responses(reads);
      check_count(rsp_total - base_total, reads, "responses in random traffic");
      match_by_address();
   endtask

   //####################
   // Main sequence
   //####################
   initial begin
      error_count     = 0;
      src_credits     = `EMESH_IN_CREDITS;
      owed_credits    = 0;
      drop_count      = 0;
      in_credit_count = 0;
      rsp_total       = 0;
      sink_open       = 1'b1;
      gate_random     = 1'b0;
      rng_state       = 32'd47;
      gate_state      = 32'd47;
      next_tag        = '0;
      in_access       = 1'b0;
      in_packet       = '0;
      out_credit      = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++)
         written[i] = 1'b0;
      reset = 1'b1;
      repeat (16) @(posedge sys_clk);
      #5;
      reset = 1'b0;
      idle_cycles(2);
      write_then_read();
      read_order_in_bank();
      filter_foreign_chip();
      stall_sink();
      random_traffic();
      $display("Errors: %0d, responses: %0d, drops: %0d", error_count, rsp_total, drop_count);
      if (error_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
      $display("Timeout: the tests did not complete within %0d cycles", WATCHDOG_CYCLES);
      $display("Errors: %0d, responses: %0d, drops: %0d", error_count, rsp_total, drop_count);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* compile.f */
+incdir+common
common/emesh_pkg.sv
hw/emesh_dispatch.sv
ememory/emesh_memory_bank.sv
hw/emesh_response_merge.sv
hw/emesh_example.sv
bench/emesh_example_tb.sv

/* Bender.yml */
package:
  name: emesh_example

export_include_dirs:
  - common

sources:
  - files:
      - common/emesh_pkg.sv
      - hw/emesh_dispatch.sv
      - ememory/emesh_memory_bank.sv
      - hw/emesh_response_merge.sv
      - hw/emesh_example.sv
  - target: test
    files:
      - bench/emesh_example_tb.sv
